// ==== common/prf_settings.svh ====
// sizing macros for the physical register file; include before using prf_pkg or any prf block.
`ifndef PRF_SETTINGS_SVH
`define PRF_SETTINGS_SVH

// datapath width of one physical register.
`define PRF_DW        64

// physical tag width, 64 registers.
`define PRF_AW        6

// instructions issued per cycle.
`define PRF_ISSUE     2

// two source operands per issued instruction.
`define PRF_NUM_READ  4

// result ports from the execution units.
`define PRF_NUM_WB    2

`endif

// ==== common/prf_pkg.sv ====
// packet types shared by the operand-read stage, the register file and the testbench.
`include "prf_settings.svh"

package prf_pkg;

   // one issue slot, sampled as a read request when valid is high.
   typedef struct packed {
      logic                valid;  // slot carries an instruction.
      logic [`PRF_AW-1:0]  src0;   // first source tag.
      logic [`PRF_AW-1:0]  src1;   // second source tag.
   } issue_t;

   // one writeback port.
   typedef struct packed {
      logic                we;     // write strobe.
      logic [`PRF_AW-1:0]  waddr;  // destination tag, never zero.
      logic [`PRF_DW-1:0]  wdata;  // result.
   } wb_t;

   // one read port of the array.
   typedef struct packed {
      logic                re;     // load enable of the read register.
      logic [`PRF_AW-1:0]  raddr;  // tag to read.
   } rd_port_t;

   // operands returned one cycle after issue.
   typedef struct packed {
      logic                valid;  // follows the issue valid of the cycle before.
      logic [`PRF_DW-1:0]  src0;   // first source value.
      logic [`PRF_DW-1:0]  src1;   // second source value.
   } operand_t;

endpackage

// ==== prf/regfile_nwnr.sv ====
// multi-port register array; registered reads see the contents before same-cycle writes.
`timescale 1ns/1ns
`include "prf_settings.svh"

module regfile_nwnr
#(
   parameter DW        = `PRF_DW,
   parameter AW        = `PRF_AW,
   parameter NUM_READ  = `PRF_NUM_READ,
   parameter NUM_WRITE = `PRF_NUM_WB
)
(
   input  logic                                clk,
   input  logic                                reset,
   input  prf_pkg::rd_port_t [NUM_READ-1:0]    rd,     // read requests.
   output logic [NUM_READ-1:0][DW-1:0]         rdata,  // data of last enabled read.
   input  prf_pkg::wb_t [NUM_WRITE-1:0]        wb      // write ports.
);

   localparam DEPTH = 1 << AW;

   logic [DW-1:0] regs [0:DEPTH-1];  // the register array.

   // write side. later ports are applied last, so the higher port
   // would win a collision, which the assertion below rules out.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            regs[i] <= '0;  // all registers start at zero.
         end
      end
      else
      begin
         for (int w = 0; w < NUM_WRITE; w++)
         begin
            if (wb[w].we)
            begin
               regs[wb[w].waddr] <= wb[w].wdata;  // commit result.
            end
         end
      end
   end

   // read side. old array value is sampled, new writes land after.
   generate
      for (genvar r = 0; r < NUM_READ; r++)
      begin : gen_rd
         always_ff @(posedge clk)
         begin
            if (rd[r].re)
            begin
               rdata[r] <= regs[rd[r].raddr];  // hold when re is low.
            end
         end
      end
   endgenerate

   // writers are distinct per cycle, rename hands out one tag per result.
   generate
      for (genvar a = 0; a < NUM_WRITE; a++)
      begin : gen_wchk
         for (genvar b = a + 1; b < NUM_WRITE; b++)
         begin : gen_pair
            a_wb_distinct: assert property (@(posedge clk) disable iff (reset)
               !(wb[a].we && wb[b].we && (wb[a].waddr == wb[b].waddr)))
               else $error("writeback ports %0d and %0d hit tag %0d", a, b, wb[a].waddr);
         end
      end
   endgenerate

endmodule

// ==== prf/prf.sv ====
// physical register file; wraps the array and makes tag 0 read as zero.
`timescale 1ns/1ns
`include "prf_settings.svh"

module prf
(
   input  logic                                     clk,
   input  logic                                     reset,
   input  prf_pkg::rd_port_t [`PRF_NUM_READ-1:0]    rd,     // from operand read.
   output logic [`PRF_NUM_READ-1:0][`PRF_DW-1:0]    rdata,  // to operand read.
   input  prf_pkg::wb_t [`PRF_NUM_WB-1:0]           wb      // from writeback.
);

   logic [`PRF_NUM_READ-1:0][`PRF_DW-1:0] rdata_raw;  // array output before masking.
   logic [`PRF_NUM_READ-1:0]              nz_q;       // last read tag was nonzero.

   regfile_nwnr
   #(
      .DW        (`PRF_DW),
      .AW        (`PRF_AW),
      .NUM_READ  (`PRF_NUM_READ),  // two sources per issue slot.
      .NUM_WRITE (`PRF_NUM_WB)
   )
   u_prf
   (
      .clk   (clk),
      .reset (reset),
      .rd    (rd),
      .rdata (rdata_raw),
      .wb    (wb)
   );

   // tag 0 decode is registered alongside the data, same enable.
   generate
      for (genvar r = 0; r < `PRF_NUM_READ; r++)
      begin : gen_zero
         always_ff @(posedge clk)
         begin
            if (reset)
            begin
               nz_q[r] <= 1'b0;  // masked output reads zero after reset.
            end
            else if (rd[r].re)
            begin
               nz_q[r] <= |rd[r].raddr;
            end
         end

         assign rdata[r] = rdata_raw[r] & {`PRF_DW{nz_q[r]}};  // r0 is hardwired zero.
      end
   endgenerate

   // rename never allocates tag 0 as a destination.
   generate
      for (genvar w = 0; w < `PRF_NUM_WB; w++)
      begin : gen_wchk
         a_no_wb_r0: assert property (@(posedge clk) disable iff (reset)
            wb[w].we |-> (wb[w].waddr != '0))
            else $error("writeback port %0d targets tag 0", w);
      end
   endgenerate

endmodule

// ==== verilog/operand_read.sv ====
// operand-read stage; issues prf reads and forwards writebacks that land in the read cycle.
`timescale 1ns/1ns
`include "prf_settings.svh"

module operand_read
(
   input  logic                                     clk,
   input  logic                                     reset,
   input  prf_pkg::issue_t [`PRF_ISSUE-1:0]         issue,     // from the scheduler.
   input  prf_pkg::wb_t [`PRF_NUM_WB-1:0]           wb,        // same-cycle results.
   output prf_pkg::rd_port_t [`PRF_NUM_READ-1:0]    rd,        // to prf.
   input  logic [`PRF_NUM_READ-1:0][`PRF_DW-1:0]    rdata,     // from prf, one cycle later.
   output prf_pkg::operand_t [`PRF_ISSUE-1:0]       operands   // to execution.
);

   localparam NIS = `PRF_ISSUE;
   localparam NRD = `PRF_NUM_READ;
   localparam NWB = `PRF_NUM_WB;

   logic [NRD-1:0]              hit_d;    // read tag matches a live writeback.
   logic [NRD-1:0][`PRF_DW-1:0] fwd_d;    // matching writeback data.
   logic [NRD-1:0]              hit_q;    // forward select for the next cycle.
   logic [NRD-1:0][`PRF_DW-1:0] fwd_q;    // forwarded data.
   logic [NIS-1:0]              valid_q;  // slot valids delayed one cycle.

   // slot k owns read ports 2k (src0) and 2k+1 (src1).
   generate
      for (genvar k = 0; k < NIS; k++)
      begin : gen_rd
         assign rd[2*k].re      = issue[k].valid;
         assign rd[2*k].raddr   = issue[k].src0;
         assign rd[2*k+1].re    = issue[k].valid;
         assign rd[2*k+1].raddr = issue[k].src1;
      end
   endgenerate

   // bypass compare. array reads old data this cycle, so catch the new value here.
   always_comb
   begin
      for (int p = 0; p < NRD; p++)
      begin
         hit_d[p] = 1'b0;
         fwd_d[p] = '0;
         for (int w = 0; w < NWB; w++)
         begin
            if (rd[p].re && wb[w].we && (wb[w].waddr == rd[p].raddr))
            begin
               hit_d[p] = 1'b1;
               fwd_d[p] = wb[w].wdata;  // higher port overrides lower.
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hit_q   <= '0;  // select the prf path, which reads zero.
         valid_q <= '0;
      end
      else
      begin
         hit_q <= hit_d;
         for (int k = 0; k < NIS; k++)
         begin
            valid_q[k] <= issue[k].valid;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      fwd_q <= fwd_d;  // only read when hit_q is set.
   end

   // final operand mux.
   generate
      for (genvar k = 0; k < NIS; k++)
      begin : gen_op
         assign operands[k].valid = valid_q[k];
         assign operands[k].src0  = hit_q[2*k]   ? fwd_q[2*k]   : rdata[2*k];
         assign operands[k].src1  = hit_q[2*k+1] ? fwd_q[2*k+1] : rdata[2*k+1];
      end
   endgenerate

endmodule

// ==== verilog/prf_subsys_top.sv ====
// top of the register-file subsystem; joins the operand-read stage and the prf.
`timescale 1ns/1ns
`include "prf_settings.svh"

module prf_subsys_top
(
   input  logic                                     clk,
   input  logic                                     reset,
   input  prf_pkg::issue_t [`PRF_ISSUE-1:0]         issue,     // issue slots.
   input  prf_pkg::wb_t [`PRF_NUM_WB-1:0]           wb,        // writeback ports.
   output prf_pkg::operand_t [`PRF_ISSUE-1:0]       operands   // operands, one cycle later.
);

   prf_pkg::rd_port_t [`PRF_NUM_READ-1:0]  rd;     // read requests into the prf.
   logic [`PRF_NUM_READ-1:0][`PRF_DW-1:0]  rdata;  // prf read data back to operand read.

   // issue side and bypass.
   operand_read u_ro
   (
      .clk      (clk),
      .reset    (reset),
      .issue    (issue),
      .wb       (wb),       // also feeds the bypass compare.
      .rd       (rd),
      .rdata    (rdata),
      .operands (operands)
   );

   // storage.
   prf u_prf
   (
      .clk   (clk),
      .reset (reset),
      .rd    (rd),
      .rdata (rdata),
      .wb    (wb)
   );

endmodule

// ==== dv/prf_model.svh ====
// reference model of the prf contents and the same-cycle forwarding rule; included in prf_tb.
`ifndef PRF_MODEL_SVH
`define PRF_MODEL_SVH

`include "prf_settings.svh"

logic [`PRF_DW-1:0] model_regs [0:(1 << `PRF_AW)-1];  // expected register contents.

// all registers are zero after reset.
function automatic void model_clear();
   for (int i = 0; i < (1 << `PRF_AW); i++)
   begin
      model_regs[i] = '0;
   end
endfunction

// value a read of tag sees one cycle later, given the writebacks of the read cycle.
function automatic logic [`PRF_DW-1:0] model_operand(input logic [`PRF_AW-1:0] tag,
                                                     input prf_pkg::wb_t [`PRF_NUM_WB-1:0] wbv);
   logic [`PRF_DW-1:0] value;
   value = (tag == '0) ? '0 : model_regs[tag];  // old contents, r0 is zero.
   for (int w = 0; w < `PRF_NUM_WB; w++)
   begin
      if (wbv[w].we && (wbv[w].waddr == tag) && (tag != '0))
      begin
         value = wbv[w].wdata;  // same-cycle result, higher port last.
      end
   end
   return value;
endfunction

// expected operand packets for one cycle of issue.
task automatic model_expect(input prf_pkg::issue_t [`PRF_ISSUE-1:0] iss,
                            input prf_pkg::wb_t [`PRF_NUM_WB-1:0] wbv,
                            output prf_pkg::operand_t [`PRF_ISSUE-1:0] exp_ops);
   exp_ops = '0;
   for (int k = 0; k < `PRF_ISSUE; k++)
   begin
      exp_ops[k].valid = iss[k].valid;
      if (iss[k].valid)
      begin
         exp_ops[k].src0 = model_operand(iss[k].src0, wbv);
         exp_ops[k].src1 = model_operand(iss[k].src1, wbv);
      end
   end
endtask

// commit the writebacks of one cycle.
function automatic void model_commit(input prf_pkg::wb_t [`PRF_NUM_WB-1:0] wbv);
   for (int w = 0; w < `PRF_NUM_WB; w++)
   begin
      if (wbv[w].we)
      begin
         model_regs[wbv[w].waddr] = wbv[w].wdata;
      end
   end
endfunction

`endif

// ==== dv/prf_tb.sv ====
// testbench for prf_subsys_top; seeded random issue and writeback traffic against a model.
`timescale 1ns/1ns
`include "prf_settings.svh"

module prf_tb;

   localparam RESET_CYCLES = 16;
   localparam IDLE_CYCLES  = 4;                                  // quiet cycles after reset.
   localparam SWEEP_CYCLES = (1 << `PRF_AW) / `PRF_NUM_READ;     // reads every tag once.
   localparam WTR_CYCLES   = 300;
   localparam ZERO_CYCLES  = 100;
   localparam FWD_CYCLES   = 100;
   localparam LAT_CYCLES   = 400;
   localparam MAX_CYCLES   = RESET_CYCLES + IDLE_CYCLES + SWEEP_CYCLES + WTR_CYCLES
                             + ZERO_CYCLES + FWD_CYCLES + LAT_CYCLES + 1 + 50;

   logic                                clk;
   logic                                reset;
   prf_pkg::issue_t   [`PRF_ISSUE-1:0]  issue;
   prf_pkg::wb_t      [`PRF_NUM_WB-1:0] wb;
   prf_pkg::operand_t [`PRF_ISSUE-1:0]  operands;

   prf_pkg::operand_t [`PRF_ISSUE-1:0] exp_q [$];  // expectations for the next cycle.
   string                              name_q [$];  // test that issued each entry.
   string                              cur_test = "none";
   int                                 value_errors = 0;
   int                                 other_errors = 0;
   int                                 checks = 0;
   int                                 cycle_count = 0;

   `include "prf_model.svh"

   prf_subsys_top dut
   (
      .clk      (clk),
      .reset    (reset),
      .issue    (issue),
      .wb       (wb),
      .operands (operands)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;  // 100 ns period.
   end

   // run limit.
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("run did not finish within %0d cycles", MAX_CYCLES);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // compare the outputs with the expectation queued one cycle earlier.
   task automatic check_outputs();
      prf_pkg::operand_t [`PRF_ISSUE-1:0] exp_ops;
      string                              tname;
      if (exp_q.size() != 0)
      begin
         exp_ops = exp_q.pop_front();
         tname   = name_q.pop_front();
         for (int k = 0; k < `PRF_ISSUE; k++)
         begin
            checks++;
            if (exp_ops[k].valid && (operands[k].valid !== 1'b1))
            begin
               $display("%s: slot %0d issued but operands valid did not follow one cycle later",
                        tname, k);
               other_errors++;
            end
            else if (!exp_ops[k].valid && (operands[k].valid !== 1'b0))
            begin
               $display("** Error [%s] slot %0d valid: expected 0, actual %b",
                        tname, k, operands[k].valid);
               value_errors++;
            end
            else if (exp_ops[k].valid)
            begin
               if (operands[k].src0 !== exp_ops[k].src0)
               begin
                  $display("** Error [%s] slot %0d src0: expected %h, actual %h",
                           tname, k, exp_ops[k].src0, operands[k].src0);
                  value_errors++;
               end
               if (operands[k].src1 !== exp_ops[k].src1)
               begin
                  $display("** Error [%s] slot %0d src1: expected %h, actual %h",
                           tname, k, exp_ops[k].src1, operands[k].src1);
                  value_errors++;
               end
            end
         end
      end
   endtask

   // one cycle: check last outputs, drive on the falling edge, update the model.
   task automatic apply_cycle(input prf_pkg::issue_t [`PRF_ISSUE-1:0] iss,
                              input prf_pkg::wb_t [`PRF_NUM_WB-1:0] wbv);
      prf_pkg::operand_t [`PRF_ISSUE-1:0] exp_ops;
      @(negedge clk);
      check_outputs();
      issue = iss;
      wb    = wbv;
      model_expect(iss, wbv, exp_ops);  // contents before this cycle's writes.
      model_commit(wbv);
      exp_q.push_back(exp_ops);
      name_q.push_back(cur_test);
   endtask

   // random writebacks with distinct nonzero tags.
   task automatic random_wb(input int we_pct, output prf_pkg::wb_t [`PRF_NUM_WB-1:0] wbv);
      logic [`PRF_AW-1:0] tag;
      logic               dup;
      wbv = '0;
      for (int w = 0; w < `PRF_NUM_WB; w++)
      begin
         dup = 1'b1;
         while (dup)
         begin
            tag = 1 + ($urandom % ((1 << `PRF_AW) - 1));  // 1 to 63.
            dup = 1'b0;
            for (int v = 0; v < w; v++)
            begin
               if (wbv[v].waddr == tag)
               begin
                  dup = 1'b1;
               end
            end
         end
         wbv[w].waddr = tag;
         wbv[w].we    = ($urandom % 100) < we_pct;
         wbv[w].wdata = {$urandom, $urandom};
      end
   endtask

   // idle outputs are all zero after reset, then every tag reads zero.
   task automatic run_reset_state();
      prf_pkg::issue_t [`PRF_ISSUE-1:0] iss;
      cur_test = "reset_state";
      for (int i = 0; i < IDLE_CYCLES; i++)
      begin
         @(negedge clk);
         checks++;
         if (operands !== '0)
         begin
            $display("** Error [%s] idle operands: expected 0, actual %h", cur_test, operands);
            value_errors++;
         end
      end
      for (int c = 0; c < SWEEP_CYCLES; c++)
      begin
         for (int k = 0; k < `PRF_ISSUE; k++)
         begin
            iss[k].valid = 1'b1;
            iss[k].src0  = `PRF_NUM_READ * c + 2 * k;
            iss[k].src1  = `PRF_NUM_READ * c + 2 * k + 1;
         end
         apply_cycle(iss, '0);
      end
   endtask

   // reads mostly pick tags written in earlier cycles.
   task automatic run_write_then_read();
      prf_pkg::issue_t [`PRF_ISSUE-1:0]  iss;
      prf_pkg::wb_t    [`PRF_NUM_WB-1:0] wbv;
      logic [`PRF_AW-1:0]                hist_q [$];
      cur_test = "write_then_read";
      for (int c = 0; c < WTR_CYCLES; c++)
      begin
         random_wb(75, wbv);
         for (int k = 0; k < `PRF_ISSUE; k++)
         begin
            iss[k].valid = ($urandom % 4) != 0;
            iss[k].src0  = $urandom;
            iss[k].src1  = $urandom;
            if ((hist_q.size() != 0) && (($urandom % 8) != 0))
            begin
               iss[k].src0 = hist_q[$urandom % hist_q.size()];
               iss[k].src1 = hist_q[$urandom % hist_q.size()];
            end
         end
         apply_cycle(iss, wbv);
         for (int w = 0; w < `PRF_NUM_WB; w++)
         begin
            if (wbv[w].we)
            begin
               hist_q.push_back(wbv[w].waddr);  // readable from the next cycle on.
            end
         end
         while (hist_q.size() > 16)
         begin
            void'(hist_q.pop_front());
         end
      end
   endtask

   // tag 0 mixed into random traffic.
   task automatic run_zero_tag();
      prf_pkg::issue_t [`PRF_ISSUE-1:0]  iss;
      prf_pkg::wb_t    [`PRF_NUM_WB-1:0] wbv;
      cur_test = "zero_tag";
      for (int c = 0; c < ZERO_CYCLES; c++)
      begin
         random_wb(75, wbv);
         for (int k = 0; k < `PRF_ISSUE; k++)
         begin
            iss[k].valid = ($urandom % 4) != 0;
            iss[k].src0  = ($urandom % 2) ? '0 : $urandom;
            iss[k].src1  = ($urandom % 2) ? '0 : $urandom;
         end
         apply_cycle(iss, wbv);
      end
   endtask

   // every source names a tag being written back in the same cycle.
   task automatic run_same_cycle_forward();
      prf_pkg::issue_t [`PRF_ISSUE-1:0]  iss;
      prf_pkg::wb_t    [`PRF_NUM_WB-1:0] wbv;
      cur_test = "same_cycle_forward";
      for (int c = 0; c < FWD_CYCLES; c++)
      begin
         random_wb(100, wbv);
         for (int k = 0; k < `PRF_ISSUE; k++)
         begin
            iss[k].valid = 1'b1;
            iss[k].src0  = wbv[$urandom % `PRF_NUM_WB].waddr;  // either port.
            iss[k].src1  = wbv[$urandom % `PRF_NUM_WB].waddr;
         end
         apply_cycle(iss, wbv);
      end
   endtask

   // full random traffic for the latency check.
   task automatic run_valid_latency();
      prf_pkg::issue_t [`PRF_ISSUE-1:0]  iss;
      prf_pkg::wb_t    [`PRF_NUM_WB-1:0] wbv;
      cur_test = "valid_latency";
      for (int c = 0; c < LAT_CYCLES; c++)
      begin
         random_wb(50, wbv);
         for (int k = 0; k < `PRF_ISSUE; k++)
         begin
            iss[k].valid = $urandom % 2;
            iss[k].src0  = $urandom;
            iss[k].src1  = $urandom;
         end
         apply_cycle(iss, wbv);
      end
   endtask

   initial
   begin
      void'($urandom(32'h2cd1_183e));  // fixed seed for the whole run.
      reset = 1'b1;
      issue = '0;
      wb    = '0;
      model_clear();
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      run_reset_state();
      run_write_then_read();
      run_zero_tag();
      run_same_cycle_forward();
      run_valid_latency();
      @(negedge clk);
      check_outputs();  // last issued cycle.
      if (exp_q.size() != 0)
      begin
         $display("%0d expected operand sets were never compared", exp_q.size());
         other_errors++;
      end
      $display("errors: %0d wrong value, %0d other, over %0d checks",
               value_errors, other_errors, checks);
      if ((value_errors + other_errors) == 0)
      begin
         $display("PASS: all tests");
      end
      else
      begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== ncpu_prf.f ====
+incdir+common
+incdir+dv
common/prf_pkg.sv
prf/regfile_nwnr.sv
prf/prf.sv
verilog/operand_read.sv
verilog/prf_subsys_top.sv
dv/prf_tb.sv
